/* bench/cn_rack_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cn_rack_tb
    import host_pkg::*;
    import neuro_pkg::*;
();

    localparam int          TB_TICKS   = 8;      // short sim period for the bench
    localparam int unsigned TB_CLK_DIV = 3;
    localparam int          SYN_WEIGHT = 64;     // DUT defaults
    localparam int          SYN_DECAY  = 2;
    localparam int          LEAK_SHIFT = 3;
    localparam int          N_CYCLES   = 20000;  // length of the random run

    logic        ep50trig;
    logic        reset_global;
    logic        i_reset_sim;
    trig_vec_t   i_trig;
    host_word_t  i_wire_data;
    logic        i_spike_ia;
    logic        i_spike_ii;
    logic        o_neuron_tick;
    logic        o_sim_tick;
    host_word_t  o_clk_div;
    host_word_t  o_extra1;
    host_word_t  o_extra2;
    fixed_t      o_drive;
    fixed_t      o_v_cn1;
    logic        o_spike_cn1;
    logic        o_spike_extra1;
    logic        o_spike_extra2;
    logic [31:0] o_spike_count;

    integer seed;
    int     spikes_seen;   // main neuron pulses over the whole run

    // reference model state, index 0 is Ia and 1 is II for the synapses
    host_word_t  m_clk_div;
    host_word_t  m_extra1;
    host_word_t  m_extra2;
    host_word_t  m_div_cnt;
    int          m_sim_cnt;
    logic        m_ntick;
    logic        m_stick;
    logic [2:0]  m_sync [2];
    logic        m_seen [2];
    current_t    m_cur [2];
    fixed_t      m_drive;
    lfsr_t       m_lfsr;
    fixed_t      m_v [3];       // cn1, extra1, extra2
    logic        m_spk [3];
    logic [31:0] m_count;

    cn_rack_top #(
        .CLK_DIV_RESET (TB_CLK_DIV),
        .TICKS_PER_SIM (TB_TICKS)
    ) i_cn_rack_top (
        .ep50trig       (ep50trig),
        .reset_global   (reset_global),
        .i_reset_sim    (i_reset_sim),
        .i_trig         (i_trig),
        .i_wire_data    (i_wire_data),
        .i_spike_ia     (i_spike_ia),
        .i_spike_ii     (i_spike_ii),
        .o_neuron_tick  (o_neuron_tick),
        .o_sim_tick     (o_sim_tick),
        .o_clk_div      (o_clk_div),
        .o_extra1       (o_extra1),
        .o_extra2       (o_extra2),
        .o_drive        (o_drive),
        .o_v_cn1        (o_v_cn1),
        .o_spike_cn1    (o_spike_cn1),
        .o_spike_extra1 (o_spike_extra1),
        .o_spike_extra2 (o_spike_extra2),
        .o_spike_count  (o_spike_count)
    );

    initial
    begin
        ep50trig = 1'b0;
        forever #2 ep50trig = ~ep50trig;  // 4 ns period
    end

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // decay by a fraction, add weight if an edge was caught, clamp at full scale
    function automatic current_t syn_next(input current_t cur, input logic seen);
        int s;
        s = int'(cur) - int'(cur >> SYN_DECAY) + (seen ? SYN_WEIGHT : 0);
        return (s > 65535) ? 16'hFFFF : current_t'(s);
    endfunction

    function automatic lfsr_t lfsr_step(input lfsr_t s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);  // right-shift galois form
    endfunction

    task automatic neuron_update(input fixed_t drive, input logic tick,
                                 inout fixed_t v, inout logic spk);
        fixed_t nxt;
        nxt = v + drive - (v >>> LEAK_SHIFT);
        if (!tick)
            spk = 1'b0;
        else if (nxt >= V_THRESH)
        begin
            v   = V_RESET;   // fire and drop back
            spk = 1'b1;
        end
        else
        begin
            v   = nxt;
            spk = 1'b0;
        end
    endtask

    task automatic clear_dynamics();
        m_div_cnt = '0;
        m_sim_cnt = 0;
        m_ntick   = 1'b0;
        m_stick   = 1'b0;
        for (int i = 0; i < 2; i++)
        begin
            m_sync[i] = '0;
            m_seen[i] = 1'b0;
            m_cur[i]  = '0;
        end
        m_drive = '0;
        m_lfsr  = LFSR_SEED;
        for (int i = 0; i < 3; i++)
        begin
            m_v[i]   = V_RESET;
            m_spk[i] = 1'b0;
        end
        m_count = '0;
    endtask

    // one clock of the whole rack, every term taken from the old state
    task automatic model_step();
        fixed_t dith;
        fixed_t drv2;
        logic   rise;
        logic   spk_in [2];
        dith      = fixed_t'({m_extra1[31:DITHER_BITS], m_lfsr[DITHER_BITS-1:0]});
        drv2      = fixed_t'(m_extra2 << FRAC_BITS);
        spk_in[0] = i_spike_ia;
        spk_in[1] = i_spike_ii;
        if (reset_global)
        begin
            clear_dynamics();
            m_clk_div = TB_CLK_DIV;
            m_extra1  = EXTRA_RESET;
            m_extra2  = EXTRA_RESET;
        end
        else
        begin
            if (i_reset_sim)
                clear_dynamics();  // registers below still load
            else
            begin
                if (m_spk[0])
                begin
                    m_count = m_count + 32'd1;  // one clock behind the pulse
                    spikes_seen++;
                end
                neuron_update(m_drive, m_ntick, m_v[0], m_spk[0]);
                neuron_update(dith, m_ntick, m_v[1], m_spk[1]);
                neuron_update(drv2, m_ntick, m_v[2], m_spk[2]);
                if (m_stick)
                    m_drive = fixed_t'((int'(m_cur[0]) + int'(m_cur[1])) << FRAC_BITS);
                if (m_ntick)
                    m_lfsr = lfsr_step(m_lfsr);
                for (int i = 0; i < 2; i++)
                begin
                    rise = m_sync[i][1] & ~m_sync[i][2];
                    if (m_stick)
                    begin
                        m_cur[i]  = syn_next(m_cur[i], m_seen[i]);
                        m_seen[i] = rise;   // edge on the tick carries over
                    end
                    else if (rise)
                        m_seen[i] = 1'b1;
                    m_sync[i] = {m_sync[i][1:0], spk_in[i]};
                end
                if (m_div_cnt >= m_clk_div)  // live divider value
                begin
                    m_div_cnt = '0;
                    m_ntick   = 1'b1;
                    m_stick   = (m_sim_cnt == TB_TICKS - 1);
                    m_sim_cnt = m_stick ? 0 : m_sim_cnt + 1;
                end
                else
                begin
                    m_div_cnt = m_div_cnt + 32'd1;
                    m_ntick   = 1'b0;
                    m_stick   = 1'b0;
                end
            end
            if (i_trig[TRIG_CLK_DIV])
                m_clk_div = i_wire_data;
            if (i_trig[TRIG_EXTRA1])
                m_extra1 = i_wire_data;
            if (i_trig[TRIG_EXTRA2])
                m_extra2 = i_wire_data;
        end
    endtask

    task automatic stop_on_error();
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input host_word_t act, input host_word_t exp);
        if (act !== exp)
        begin
            $display("[FAIL] time %0t: %s is %h, expected %h", $time, name, act, exp);
            stop_on_error();
        end
    endtask

    task automatic check_fixed(input string name, input fixed_t act, input fixed_t exp);
        if (act !== exp)
        begin
            $display("[FAIL] time %0t: %s is %0d, expected %0d", $time, name, act, exp);
            stop_on_error();
        end
    endtask

    task automatic check_bit(input string name, input logic act, input logic exp);
        if (act !== exp)
        begin
            $display("[FAIL] time %0t: %s is %b, expected %b", $time, name, act, exp);
            stop_on_error();
        end
    endtask

    task automatic check_count(input string name, input logic [31:0] act,
                               input logic [31:0] exp);
        if (act !== exp)
        begin
            $display("[FAIL] time %0t: %s is %0d, expected %0d", $time, name, act, exp);
            stop_on_error();
        end
    endtask

    // looks only at falling edges, where the registered outputs are settled
    task automatic wait_tick(input logic want_sim, input int limit, input string what);
        int n;
        n = 0;
        @(negedge ep50trig);
        while ((want_sim ? o_sim_tick : o_neuron_tick) !== 1'b1)
        begin
            n++;
            if (n > limit)
            begin
                $display("timeout: no %s within %0d cycles", what, limit);
                stop_on_error();
            end
            @(negedge ep50trig);
        end
    endtask

    task automatic drive_stimulus();
        trig_vec_t  t;
        host_word_t d;
        t = '0;
        d = host_word_t'($random(seed));  // junk data, ignored without a strobe
        case (rand_below(32))
            0:
            begin
                t[TRIG_CLK_DIV] = 1'b1;
                d = 1 + rand_below(6);
            end
            1:
            begin
                t[TRIG_EXTRA1] = 1'b1;
                d = host_word_t'(rand_below(65536)) - 32'd16384;  // about -16 to +48
            end
            2:
            begin
                t[TRIG_EXTRA2] = 1'b1;
                d = rand_below(16);
            end
            3:
            begin
                t = trig_vec_t'(rand_below(65536));  // several strobes at once
                d = 1 + rand_below(6);
            end
            default:
                t = '0;
        endcase
        i_trig      <= t;
        i_wire_data <= d;
        i_spike_ia  <= (rand_below(16) == 0);
        i_spike_ii  <= (rand_below(16) == 0);
        i_reset_sim <= (rand_below(1024) == 0);  // rare soft reset
    endtask

    always @(posedge ep50trig)
        model_step();

    // outputs settle well before the falling edge
    always @(negedge ep50trig)
    begin
        if (!reset_global)
        begin
            check_word("o_clk_div", o_clk_div, m_clk_div);
            check_word("o_extra1", o_extra1, m_extra1);
            check_word("o_extra2", o_extra2, m_extra2);
            check_bit("o_neuron_tick", o_neuron_tick, m_ntick);
            check_bit("o_sim_tick", o_sim_tick, m_stick);
            check_fixed("o_drive", o_drive, m_drive);
            check_fixed("o_v_cn1", o_v_cn1, m_v[0]);
            check_bit("o_spike_cn1", o_spike_cn1, m_spk[0]);
            check_bit("o_spike_extra1", o_spike_extra1, m_spk[1]);
            check_bit("o_spike_extra2", o_spike_extra2, m_spk[2]);
            check_count("o_spike_count", o_spike_count, m_count);
        end
    end

    initial
    begin
        seed         = 32'h85f9_dfc8;
        spikes_seen  = 0;
        reset_global = 1'b1;
        i_reset_sim  = 1'b0;
        i_trig       = '0;
        i_wire_data  = '0;
        i_spike_ia   = 1'b0;
        i_spike_ii   = 1'b0;
        repeat (16) @(posedge ep50trig);
        reset_global <= 1'b0;
        wait_tick(1'b0, 2 * (TB_CLK_DIV + 1), "neuron tick after reset");
        wait_tick(1'b1, 2 * TB_TICKS * (TB_CLK_DIV + 1), "sim tick after reset");
        repeat (N_CYCLES)
        begin
            @(posedge ep50trig);
            drive_stimulus();
        end
        @(posedge ep50trig);
        i_trig      <= '0;
        i_spike_ia  <= 1'b0;
        i_spike_ii  <= 1'b0;
        i_reset_sim <= 1'b0;
        wait_tick(1'b1, 8 * TB_TICKS * 8, "sim tick after the random run");
        if (spikes_seen == 0)
        begin
            $display("main neuron never fired during the random run");
            stop_on_error();
        end
        else
        begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* design/cn_rack_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cn_rack_top
    import host_pkg::*;
    import neuro_pkg::*;
#(
    parameter int unsigned CLK_DIV_RESET   = 381,  // divider after power-up
    parameter int          TICKS_PER_SIM   = 128,  // neuron ticks per ms
    parameter int          SYN_WEIGHT      = 64,
    parameter int          SYN_DECAY_SHIFT = 2,
    parameter int          LEAK_SHIFT      = 3
)
(
    input  wire             ep50trig,
    input  wire             reset_global,
    input  wire             i_reset_sim,
    input  wire trig_vec_t  i_trig,
    input  wire host_word_t i_wire_data,
    input  wire             i_spike_ia,      // Ia afferent line
    input  wire             i_spike_ii,      // II afferent line
    output logic            o_neuron_tick,
    output logic            o_sim_tick,
    output host_word_t      o_clk_div,
    output host_word_t      o_extra1,
    output host_word_t      o_extra2,
    output fixed_t          o_drive,
    output fixed_t          o_v_cn1,
    output logic            o_spike_cn1,
    output logic            o_spike_extra1,
    output logic            o_spike_extra2,
    output logic [31:0]     o_spike_count
);

    current_t current_ia;
    current_t current_ii;
    fixed_t   drive_extra1;   // dithered register 1
    fixed_t   drive_extra2;   // register 2 scaled to Q.10

    param_bank #(
        .CLK_DIV_RESET (host_word_t'(CLK_DIV_RESET))
    ) i_param_bank (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_trig       (i_trig),
        .i_wire_data  (i_wire_data),
        .o_clk_div    (o_clk_div),
        .o_extra1     (o_extra1),
        .o_extra2     (o_extra2)
    );

    tick_gen #(
        .TICKS_PER_SIM (TICKS_PER_SIM)
    ) i_tick_gen (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_reset_sim   (i_reset_sim),
        .i_clk_div     (o_clk_div),
        .o_neuron_tick (o_neuron_tick),
        .o_sim_tick    (o_sim_tick)
    );

    synapse_simple #(
        .SYN_WEIGHT      (SYN_WEIGHT),
        .SYN_DECAY_SHIFT (SYN_DECAY_SHIFT)
    ) i_syn_ia (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_reset_sim  (i_reset_sim),
        .i_sim_tick   (o_sim_tick),
        .i_spike      (i_spike_ia),
        .o_current    (current_ia)
    );

    synapse_simple #(
        .SYN_WEIGHT      (SYN_WEIGHT),
        .SYN_DECAY_SHIFT (SYN_DECAY_SHIFT)
    ) i_syn_ii (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_reset_sim  (i_reset_sim),
        .i_sim_tick   (o_sim_tick),
        .i_spike      (i_spike_ii),
        .o_current    (current_ii)
    );

    drive_mixer i_drive_mixer (
        .ep50trig       (ep50trig),
        .reset_global   (reset_global),
        .i_reset_sim    (i_reset_sim),
        .i_neuron_tick  (o_neuron_tick),
        .i_sim_tick     (o_sim_tick),
        .i_current_ia   (current_ia),
        .i_current_ii   (current_ii),
        .i_extra1       (o_extra1),
        .i_extra2       (o_extra2),
        .o_drive        (o_drive),
        .o_drive_extra1 (drive_extra1),
        .o_drive_extra2 (drive_extra2)
    );

    // main nucleus neuron, fed by both afferents
    spiking_neuron #(
        .LEAK_SHIFT (LEAK_SHIFT)
    ) i_cn1 (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_reset_sim   (i_reset_sim),
        .i_neuron_tick (o_neuron_tick),
        .i_drive       (o_drive),
        .o_v           (o_v_cn1),
        .o_spike       (o_spike_cn1)
    );

    spiking_neuron #(
        .LEAK_SHIFT (LEAK_SHIFT)
    ) i_extra_cn1 (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_reset_sim   (i_reset_sim),
        .i_neuron_tick (o_neuron_tick),
        .i_drive       (drive_extra1),
        .o_v           (),                // potential not read back
        .o_spike       (o_spike_extra1)
    );

    spiking_neuron #(
        .LEAK_SHIFT (LEAK_SHIFT)
    ) i_extra_cn2 (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_reset_sim   (i_reset_sim),
        .i_neuron_tick (o_neuron_tick),
        .i_drive       (drive_extra2),
        .o_v           (),
        .o_spike       (o_spike_extra2)
    );

    spike_counter i_spike_counter (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_reset_sim  (i_reset_sim),
        .i_spike      (o_spike_cn1),
        .o_count      (o_spike_count)
    );

endmodule

`default_nettype wire

/* design/drive_mixer.sv */
`timescale 1ns/1ps
`default_nettype none

module drive_mixer
    import host_pkg::*;
    import neuro_pkg::*;
(
    input  wire             ep50trig,
    input  wire             reset_global,
    input  wire             i_reset_sim,
    input  wire             i_neuron_tick,
    input  wire             i_sim_tick,
    input  wire current_t   i_current_ia,    // afferent Ia synapse
    input  wire current_t   i_current_ii,    // afferent II synapse
    input  wire host_word_t i_extra1,        // raw Q.10 word from host
    input  wire host_word_t i_extra2,        // integer drive from host
    output fixed_t          o_drive,         // main neuron drive, held per sim tick
    output fixed_t          o_drive_extra1,
    output fixed_t          o_drive_extra2
);

    fixed_t        syn_sum;   // integer sum, zero extended
    lfsr_t         lfsr_q;
    lfsr_t         lfsr_nxt;
    dither_drive_u dith;

    assign syn_sum = fixed_t'(i_current_ia) + fixed_t'(i_current_ii);

    // galois step, shift right and fold taps when a one falls out
    assign lfsr_nxt = lfsr_q[0] ? ((lfsr_q >> 1) ^ LFSR_TAPS) : (lfsr_q >> 1);

    // sum sampled before the synapses take their own tick update
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
            o_drive <= '0;
        else if (i_reset_sim)
            o_drive <= '0;
        else if (i_sim_tick)
            o_drive <= syn_sum <<< FRAC_BITS;
    end

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
            lfsr_q <= LFSR_SEED;
        else if (i_reset_sim)
            lfsr_q <= LFSR_SEED;
        else if (i_neuron_tick)
            lfsr_q <= lfsr_nxt;  // fresh noise each membrane update
    end

    always_comb
    begin
        dith.fld.coarse = i_extra1[31:DITHER_BITS];   // keep host's upper bits
        dith.fld.dither = lfsr_q[DITHER_BITS-1:0];    // noise in the fraction
    end

    assign o_drive_extra1 = dith.raw;
    assign o_drive_extra2 = fixed_t'(i_extra2) <<< FRAC_BITS;

    // zero is the galois lock-up state, seed and reset must keep us out of it
    a_lfsr_alive: assert property (@(posedge ep50trig) disable iff (reset_global)
        lfsr_q != '0);

endmodule

`default_nettype wire

/* design/host_pkg.sv */
`default_nettype none

package host_pkg;

    localparam int HOST_WORD_W = 32;  // two 16-bit wire endpoints side by side
    localparam int TRIG_W      = 16;  // one trigger endpoint

    typedef logic [HOST_WORD_W-1:0] host_word_t;  // data word held by the host
    typedef logic [TRIG_W-1:0]      trig_vec_t;   // one-clock load strobes

    // trigger bit per register
    localparam int TRIG_CLK_DIV = 7;   // neuron tick divider
    localparam int TRIG_EXTRA1  = 8;   // dithered extra drive
    localparam int TRIG_EXTRA2  = 9;   // plain extra drive

    // both extra drives come up silent
    localparam host_word_t EXTRA_RESET = '0;

endpackage

`default_nettype wire

/* design/neuro_pkg.sv */
`default_nettype none

package neuro_pkg;

    localparam int FRAC_BITS = 10;  // Q.10 everywhere in the membrane path

    typedef logic signed [31:0] fixed_t;    // drive and potential
    typedef logic [15:0]        current_t;  // synaptic current, integer units

    localparam fixed_t V_THRESH = 32'sd30 <<< FRAC_BITS;  // 30 mV -> 30720
    localparam fixed_t V_RESET  = '0;                     // potential after a spike

    // random source for the dithered drive
    typedef logic [31:0] lfsr_t;
    localparam lfsr_t LFSR_TAPS = 32'h8020_0003;  // galois feedback mask
    localparam lfsr_t LFSR_SEED = 32'h0000_0001;  // any nonzero state works

    localparam int DITHER_BITS = 8;  // low bits replaced by noise

    typedef struct packed {
        logic [31-DITHER_BITS:0] coarse;  // upper host register bits
        logic [DITHER_BITS-1:0]  dither;  // lfsr low bits
    } dither_fields_t;

    // one word, written as fields by the mixer, read raw by the neuron
    typedef union packed {
        fixed_t         raw;
        dither_fields_t fld;
    } dither_drive_u;

endpackage

`default_nettype wire

/* design/param_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module param_bank
    import host_pkg::*;
#(
    parameter host_word_t CLK_DIV_RESET = 32'd381  // 381 gives real-time speed
)
(
    input  wire             ep50trig,
    input  wire             reset_global,
    input  wire trig_vec_t  i_trig,       // one-clock load strobes
    input  wire host_word_t i_wire_data,  // held by host around the strobe
    output host_word_t      o_clk_div,
    output host_word_t      o_extra1,
    output host_word_t      o_extra2
);

    // host settings hold across a soft reset
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            o_clk_div <= CLK_DIV_RESET;
            o_extra1  <= EXTRA_RESET;
            o_extra2  <= EXTRA_RESET;
        end
        else
        begin
            // several strobes may fire together, each loads the same word
            if (i_trig[TRIG_CLK_DIV])
                o_clk_div <= i_wire_data;
            if (i_trig[TRIG_EXTRA1])
                o_extra1 <= i_wire_data;
            if (i_trig[TRIG_EXTRA2])
                o_extra2 <= i_wire_data;
        end
    end

    // a register may only move right after its own strobe
    a_clk_div_hold: assert property (@(posedge ep50trig) disable iff (reset_global)
        !$past(i_trig[TRIG_CLK_DIV]) |-> $stable(o_clk_div));

    a_extra1_hold: assert property (@(posedge ep50trig) disable iff (reset_global)
        !$past(i_trig[TRIG_EXTRA1]) |-> $stable(o_extra1));

    a_extra2_hold: assert property (@(posedge ep50trig) disable iff (reset_global)
        !$past(i_trig[TRIG_EXTRA2]) |-> $stable(o_extra2));

endmodule

`default_nettype wire

/* design/spike_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module spike_counter
(
    input  wire         ep50trig,
    input  wire         reset_global,
    input  wire         i_reset_sim,
    input  wire         i_spike,     // single-clock pulse from the main neuron
    output logic [31:0] o_count      // wraps, host reads it as two halves
);

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
            o_count <= '0;
        else if (i_reset_sim)
            o_count <= '0;
        else if (i_spike)
            o_count <= o_count + 32'd1;  // visible the clock after the pulse
    end

endmodule

`default_nettype wire

/* design/spiking_neuron.sv */
`timescale 1ns/1ps
`default_nettype none

module spiking_neuron
    import neuro_pkg::*;
#(
    parameter int LEAK_SHIFT = 3  // leak 1/8 of the potential per tick
)
(
    input  wire         ep50trig,
    input  wire         reset_global,
    input  wire         i_reset_sim,
    input  wire         i_neuron_tick,
    input  wire fixed_t i_drive,       // Q.10 input current
    output fixed_t      o_v,           // membrane potential, Q.10
    output logic        o_spike        // one clock per firing
);

    fixed_t v_nxt;
    logic   fire;

    // leaky integrate, arithmetic shift keeps the sign of a negative potential
    assign v_nxt = o_v + i_drive - (o_v >>> LEAK_SHIFT);
    assign fire  = (v_nxt >= V_THRESH);

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            o_v     <= V_RESET;
            o_spike <= 1'b0;
        end
        else if (i_reset_sim)
        begin
            o_v     <= V_RESET;
            o_spike <= 1'b0;
        end
        else if (i_neuron_tick)
        begin
            o_v     <= fire ? V_RESET : v_nxt;
            o_spike <= fire;
        end
        else
            o_spike <= 1'b0;  // pulse ends after one clock
    end

    // threshold crossing always resets, so the stored value stays below it
    a_v_below_thresh: assert property (@(posedge ep50trig) disable iff (reset_global)
        o_v < V_THRESH);

    // ticks are at least two clocks apart in normal use
    a_spike_single: assert property (@(posedge ep50trig) disable iff (reset_global)
        o_spike |=> !o_spike);

endmodule

`default_nettype wire

/* design/synapse_simple.sv */
`timescale 1ns/1ps
`default_nettype none

module synapse_simple
    import neuro_pkg::*;
#(
    parameter int SYN_WEIGHT      = 64,  // current per captured spike
    parameter int SYN_DECAY_SHIFT = 2    // decay by 1/4 per sim tick
)
(
    input  wire      ep50trig,
    input  wire      reset_global,
    input  wire      i_reset_sim,
    input  wire      i_sim_tick,
    input  wire      i_spike,     // from another fpga, asynchronous
    output current_t o_current
);

    logic [2:0]  spike_sync;   // two sync flops plus an edge history flop
    logic        spike_rise;
    logic        spike_seen;   // sticky until next sim tick
    current_t    decayed;
    logic [16:0] cur_sum;      // one spare bit for saturation

    assign spike_rise = spike_sync[1] & ~spike_sync[2];

    assign decayed = o_current - (o_current >> SYN_DECAY_SHIFT);
    assign cur_sum = {1'b0, decayed} + (spike_seen ? 17'(SYN_WEIGHT) : 17'd0);

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            spike_sync <= '0;
            spike_seen <= 1'b0;
            o_current  <= '0;
        end
        else if (i_reset_sim)
        begin
            spike_sync <= '0;
            spike_seen <= 1'b0;
            o_current  <= '0;
        end
        else
        begin
            spike_sync <= {spike_sync[1:0], i_spike};
            if (i_sim_tick)
            begin
                o_current  <= cur_sum[16] ? 16'hFFFF : cur_sum[15:0];  // clamp at full scale
                spike_seen <= spike_rise;  // an edge on the tick goes to the next one
            end
            else if (spike_rise)
                spike_seen <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* design/tick_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tick_gen
    import host_pkg::*;
#(
    parameter int TICKS_PER_SIM = 128  // neuron ticks per 1 ms of model time
)
(
    input  wire             ep50trig,
    input  wire             reset_global,
    input  wire             i_reset_sim,
    input  wire host_word_t i_clk_div,      // period minus one, in clocks
    output logic            o_neuron_tick,
    output logic            o_sim_tick
);

    localparam int SIM_W = (TICKS_PER_SIM > 1) ? $clog2(TICKS_PER_SIM) : 1;

    host_word_t       div_cnt;   // clocks since last neuron tick
    logic [SIM_W-1:0] sim_cnt;   // neuron ticks since last sim tick
    logic             div_wrap;
    logic             sim_wrap;

    // compare against the live divider, a smaller value cuts the period at once
    assign div_wrap = (div_cnt >= i_clk_div);
    assign sim_wrap = (sim_cnt == SIM_W'(TICKS_PER_SIM - 1));

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            div_cnt       <= '0;
            sim_cnt       <= '0;
            o_neuron_tick <= 1'b0;
            o_sim_tick    <= 1'b0;
        end
        else if (i_reset_sim)
        begin
            div_cnt       <= '0;
            sim_cnt       <= '0;
            o_neuron_tick <= 1'b0;
            o_sim_tick    <= 1'b0;
        end
        else if (div_wrap)
        begin
            div_cnt       <= '0;
            o_neuron_tick <= 1'b1;
            o_sim_tick    <= sim_wrap;                       // every Nth neuron tick
            sim_cnt       <= sim_wrap ? '0 : sim_cnt + 1'b1;
        end
        else
        begin
            div_cnt       <= div_cnt + 1'b1;
            o_neuron_tick <= 1'b0;
            o_sim_tick    <= 1'b0;
        end
    end

    // sim tick must line up with a neuron tick or mixer and neurons drift apart
    a_sim_on_neuron: assert property (@(posedge ep50trig) disable iff (reset_global)
        o_sim_tick |-> o_neuron_tick);

endmodule

`default_nettype wire

/* list.f */
design/host_pkg.sv
design/neuro_pkg.sv
design/param_bank.sv
design/tick_gen.sv
design/synapse_simple.sv
design/drive_mixer.sv
design/spiking_neuron.sv
design/spike_counter.sv
design/cn_rack_top.sv
bench/cn_rack_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the cn_rack testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f list.f --top-module cn_rack_tb \
    --Mdir obj_dir -o cn_rack_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/cn_rack_sim > "$log" 2>&1
status=$?
cat "$log"

if grep -q "Done: errors found" "$log"; then
    echo "simulation failed"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

echo "simulation passed"
exit 0
